//--- rtl/dma_s2mm_config.svh
`ifndef DMA_S2MM_CONFIG_SVH
`define DMA_S2MM_CONFIG_SVH

// stream and AXI data width in bits
`define DMA_DATA_WIDTH 32

// longest incrementing burst in beats
`define DMA_MAX_BURST_LEN 16

// queued commands ahead of the planner
`define DMA_CMD_FIFO_DEPTH 4

// write data buffer, two full bursts
`define DMA_WDATA_FIFO_DEPTH 32

// descriptor slots, the one-hot pointers rely on four
`define DMA_BURST_SLOTS 4

`endif

//--- rtl/dma_cmd_pkg.sv
`include "dma_s2mm_config.svh"

package dma_cmd_pkg;

	// write command as it arrives on the command port
	typedef struct packed
	{
		logic [23:0] btt; // bytes to transfer
		logic [31:0] addr; // base address
		logic fixed; // 1: fixed burst, 0: incrementing
	} dma_cmd_t;

	// one AXI burst cut from a command
	typedef struct packed
	{
		logic [31:0] addr;
		logic [7:0] len_m1; // beats minus one
		logic fixed;
		logic last_of_cmd; // final burst of its command
	} burst_desc_t;

	typedef logic [`DMA_BURST_SLOTS-1:0] slot_onehot_t;

	localparam int BYTES_PER_BEAT = `DMA_DATA_WIDTH / 8;
	localparam int BEAT_SHIFT = $clog2(BYTES_PER_BEAT);

endpackage

//--- rtl/axi_wr_pkg.sv
`include "dma_s2mm_config.svh"

package axi_wr_pkg;

	// wrap and the reserved code are never issued
	typedef enum logic [1:0]
	{
		AXI_BURST_FIXED = 2'b00,
		AXI_BURST_INCR = 2'b01
	} axi_burst_e;

	// AW request without the constant fields
	typedef struct packed
	{
		logic [31:0] addr;
		logic [7:0] len;
		axi_burst_e burst;
	} aw_req_t;

	typedef struct packed
	{
		logic [`DMA_DATA_WIDTH-1:0] data;
		logic [`DMA_DATA_WIDTH/8-1:0] strb;
		logic last;
	} w_beat_t;

	// beats in one 4 KB page
	localparam int AXI_4KB_BEATS = 4096 / (`DMA_DATA_WIDTH / 8);

endpackage

//--- rtl/sync_fifo.sv
module sync_fifo #(
	parameter type T = logic,
	parameter int DEPTH = 4
)(
	input logic m_axi_aclk,
	input logic m_axi_aresetn,

	input T wr_data_i,
	input logic wr_valid_i,
	output logic wr_ready_o,

	output T rd_data_o,
	output logic rd_valid_o,
	input logic rd_ready_i
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	T mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count; // occupancy
	logic wr_fire;
	logic rd_fire;

	assign wr_ready_o = count != CNT_W'(DEPTH);
	assign rd_valid_o = count != '0;
	assign rd_data_o = mem[rd_ptr]; // head shows as soon as it is written

	assign wr_fire = wr_valid_i & wr_ready_o;
	assign rd_fire = rd_valid_o & rd_ready_i;

	always_ff @(posedge m_axi_aclk)
	begin
		if (wr_fire)
			mem[wr_ptr] <= wr_data_i;
	end

	always_ff @(posedge m_axi_aclk or negedge m_axi_aresetn)
	begin
		if (!m_axi_aresetn)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end
		else
		begin
			if (wr_fire)
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (rd_fire)
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			if (wr_fire != rd_fire)
				count <= wr_fire ? count + 1'b1 : count - 1'b1;
		end
	end

endmodule

//--- rtl/s2mm_burst_planner.sv
`include "dma_s2mm_config.svh"

module s2mm_burst_planner (
	input logic m_axi_aclk,
	input logic m_axi_aresetn,

	input dma_cmd_pkg::dma_cmd_t cmd_i,
	input logic cmd_valid_i,
	output logic cmd_ready_o,

	input logic slot_free_i, // slot under the plan pointer is free
	output dma_cmd_pkg::burst_desc_t desc_o,
	output logic launch_o
);

	import dma_cmd_pkg::*;
	import axi_wr_pkg::*;

	localparam int INCR_CAP = `DMA_MAX_BURST_LEN;
	localparam int FIXED_CAP = (INCR_CAP > 16) ? 16 : INCR_CAP;
	localparam int WIN_W = $clog2(AXI_4KB_BEATS);

	typedef enum logic [1:0]
	{
		IDLE,
		CALC0,
		CALC1,
		LAUNCH
	} state_e;

	state_e state;
	logic cmd_fire;
	logic [24:0] term_addr; // byte count plus low address bits
	logic [23:0] beats; // whole beats of the command
	logic [23:0] cap_m1;
	logic [23:0] rmn_m1; // beats still to plan minus one
	logic [WIN_W-1:0] win_m1; // beats left in the 4 KB page minus one
	logic [31:0] addr_q;
	logic fixed_q;
	logic [7:0] min_res;
	logic le0_q; // remainder chosen against the cap
	logic le0;
	logic le1;
	logic last_q;

	assign cmd_ready_o = state == IDLE;
	assign cmd_fire = cmd_valid_i & cmd_ready_o;

	assign term_addr = 25'(cmd_i.btt) + 25'(cmd_i.addr[BEAT_SHIFT-1:0]);
	assign beats = 24'(term_addr[24:BEAT_SHIFT]) + 24'(|term_addr[BEAT_SHIFT-1:0]);

	assign cap_m1 = fixed_q ? 24'(FIXED_CAP - 1) : 24'(INCR_CAP - 1);
	assign le0 = rmn_m1 <= cap_m1;
	assign le1 = {16'd0, min_res} <= 24'(win_m1);

	assign launch_o = state == LAUNCH;
	assign desc_o.addr = addr_q;
	assign desc_o.len_m1 = min_res;
	assign desc_o.fixed = fixed_q;
	assign desc_o.last_of_cmd = last_q;

	always_ff @(posedge m_axi_aclk or negedge m_axi_aresetn)
	begin
		if (!m_axi_aresetn)
			state <= IDLE;
		else
		begin
			case (state)
				IDLE: if (cmd_fire) state <= CALC0;
				CALC0: if (slot_free_i) state <= CALC1; // wait for a slot
				CALC1: state <= LAUNCH;
				default: state <= last_q ? IDLE : CALC0;
			endcase
		end
	end

	always_ff @(posedge m_axi_aclk)
	begin
		if (cmd_fire)
		begin
			rmn_m1 <= beats - 24'd1;
			win_m1 <= ~cmd_i.addr[11:BEAT_SHIFT];
			addr_q <= {cmd_i.addr[31:BEAT_SHIFT], {BEAT_SHIFT{1'b0}}}; // beat aligned
			fixed_q <= cmd_i.fixed;
		end
		else if (state == CALC0 && slot_free_i)
		begin
			min_res <= le0 ? rmn_m1[7:0] : cap_m1[7:0];
			le0_q <= le0;
		end
		else if (state == CALC1)
		begin
			// fixed bursts never move, so the page limit does not apply
			if (!fixed_q && !le1)
				min_res <= win_m1[7:0];
			last_q <= le0_q & (fixed_q | le1);
		end
		else if (state == LAUNCH && !last_q)
		begin
			rmn_m1 <= rmn_m1 - 24'(min_res) - 24'd1;
			if (!fixed_q)
			begin
				win_m1 <= win_m1 - WIN_W'(min_res) - 1'b1; // wraps into next page
				addr_q <= addr_q + ((32'(min_res) + 32'd1) << BEAT_SHIFT);
			end
		end
	end

endmodule

//--- rtl/s2mm_burst_table.sv
`include "dma_s2mm_config.svh"

module s2mm_burst_table (
	input logic m_axi_aclk,
	input logic m_axi_aresetn,

	input dma_cmd_pkg::burst_desc_t desc_i,
	input logic launch_i,
	output logic slot_free_o,

	output logic [7:0] fill_len_o,
	output logic fill_last_of_cmd_o,
	output logic fill_active_o,
	input logic burst_filled_i,

	output axi_wr_pkg::aw_req_t aw_o,
	output logic awvalid_o,
	input logic awready_i,

	input logic bvalid_i
);

	import dma_cmd_pkg::*;
	import axi_wr_pkg::*;

	// lifecycle flag bits, a slot rotates through them in order
	localparam int ST_FREE = 0;
	localparam int ST_PLANNED = 1;
	localparam int ST_READY = 2;
	localparam int ST_FLIGHT = 3;

	logic [3:0] flags [`DMA_BURST_SLOTS];
	burst_desc_t desc_q [`DMA_BURST_SLOTS];
	slot_onehot_t plan_ptr;
	slot_onehot_t fill_ptr;
	slot_onehot_t issue_ptr;
	slot_onehot_t retire_ptr;
	burst_desc_t fill_desc;
	burst_desc_t issue_desc;
	logic retire_ok;

	function automatic logic in_state(input slot_onehot_t ptr, input int st);
		logic hit;
		hit = 1'b0;
		for (int i = 0; i < `DMA_BURST_SLOTS; i++)
			hit |= ptr[i] & flags[i][st];
		return hit;
	endfunction

	function automatic burst_desc_t sel_desc(input slot_onehot_t ptr);
		burst_desc_t d;
		d = '0;
		for (int i = 0; i < `DMA_BURST_SLOTS; i++)
			if (ptr[i])
				d = desc_q[i];
		return d;
	endfunction

	function automatic slot_onehot_t rot(input slot_onehot_t ptr);
		return {ptr[`DMA_BURST_SLOTS-2:0], ptr[`DMA_BURST_SLOTS-1]};
	endfunction

	assign slot_free_o = in_state(plan_ptr, ST_FREE);
	assign fill_active_o = in_state(fill_ptr, ST_PLANNED);
	assign awvalid_o = in_state(issue_ptr, ST_READY);
	assign retire_ok = in_state(retire_ptr, ST_FLIGHT);

	assign fill_desc = sel_desc(fill_ptr);
	assign issue_desc = sel_desc(issue_ptr);

	assign fill_len_o = fill_desc.len_m1;
	assign fill_last_of_cmd_o = fill_desc.last_of_cmd;

	assign aw_o.addr = issue_desc.addr;
	assign aw_o.len = issue_desc.len_m1;
	assign aw_o.burst = issue_desc.fixed ? AXI_BURST_FIXED : AXI_BURST_INCR;

	always_ff @(posedge m_axi_aclk)
	begin
		for (int i = 0; i < `DMA_BURST_SLOTS; i++)
			if (launch_i && plan_ptr[i] && flags[i][ST_FREE])
				desc_q[i] <= desc_i;
	end

	always_ff @(posedge m_axi_aclk or negedge m_axi_aresetn)
	begin
		if (!m_axi_aresetn)
		begin
			for (int i = 0; i < `DMA_BURST_SLOTS; i++)
				flags[i] <= 4'b0001;
			plan_ptr <= slot_onehot_t'(1);
			fill_ptr <= slot_onehot_t'(1);
			issue_ptr <= slot_onehot_t'(1);
			retire_ptr <= slot_onehot_t'(1);
		end
		else
		begin
			// one slot holds one state, so at most one event hits it
			for (int i = 0; i < `DMA_BURST_SLOTS; i++)
				if ((plan_ptr[i] & flags[i][ST_FREE] & launch_i) |
					(fill_ptr[i] & flags[i][ST_PLANNED] & burst_filled_i) |
					(issue_ptr[i] & flags[i][ST_READY] & awready_i) |
					(retire_ptr[i] & flags[i][ST_FLIGHT] & bvalid_i))
					flags[i] <= {flags[i][2:0], flags[i][3]};
			if (launch_i && slot_free_o)
				plan_ptr <= rot(plan_ptr);
			if (burst_filled_i && fill_active_o)
				fill_ptr <= rot(fill_ptr);
			if (awready_i && awvalid_o)
				issue_ptr <= rot(issue_ptr);
			if (bvalid_i && retire_ok) // responses come back in AW order
				retire_ptr <= rot(retire_ptr);
		end
	end

endmodule

//--- rtl/s2mm_beat_counter.sv
module s2mm_beat_counter (
	input logic m_axi_aclk,
	input logic m_axi_aresetn,

	input logic beat_fire_i, // beat accepted into the data FIFO
	input logic in_last_i, // stream tlast of that beat
	input logic [7:0] fill_len_i, // burst length minus one
	input logic fill_last_of_cmd_i,

	output logic beat_last_o,
	output logic burst_filled_o,
	output logic mismatch_o
);

	logic [7:0] cnt;
	logic expect_last; // end of the whole command

	assign beat_last_o = cnt == fill_len_i;
	assign burst_filled_o = beat_fire_i & beat_last_o;
	assign expect_last = beat_last_o & fill_last_of_cmd_i;

	always_ff @(posedge m_axi_aclk or negedge m_axi_aresetn)
	begin
		if (!m_axi_aresetn)
			cnt <= 8'd0;
		else if (beat_fire_i)
			cnt <= beat_last_o ? 8'd0 : cnt + 8'd1;
	end

	// stream tlast and the command end must agree beat for beat
	always_ff @(posedge m_axi_aclk or negedge m_axi_aresetn)
	begin
		if (!m_axi_aresetn)
			mismatch_o <= 1'b0;
		else if (beat_fire_i && (in_last_i != expect_last))
			mismatch_o <= 1'b1; // sticky
	end

endmodule

//--- rtl/dma_s2mm_top.sv
`include "dma_s2mm_config.svh"

module dma_s2mm_top (
	input logic m_axi_aclk,
	input logic m_axi_aresetn,

	input dma_cmd_pkg::dma_cmd_t s_cmd_data_i,
	input logic s_cmd_valid_i,
	output logic s_cmd_ready_o,

	input logic [`DMA_DATA_WIDTH-1:0] s_axis_data_i,
	input logic [`DMA_DATA_WIDTH/8-1:0] s_axis_keep_i,
	input logic s_axis_last_i,
	input logic s_axis_valid_i,
	output logic s_axis_ready_o,

	output axi_wr_pkg::aw_req_t m_axi_aw_o,
	output logic m_axi_awvalid_o,
	input logic m_axi_awready_i,

	output axi_wr_pkg::w_beat_t m_axi_w_o,
	output logic m_axi_wvalid_o,
	input logic m_axi_wready_i,

	input logic [1:0] m_axi_bresp_i,
	input logic m_axi_bvalid_i,

	output logic [1:0] err_flag_o // {response error, beat count mismatch}
);

	import dma_cmd_pkg::*;
	import axi_wr_pkg::*;

	dma_cmd_t cmd;
	logic cmd_valid;
	logic cmd_ready;
	burst_desc_t desc;
	logic launch;
	logic slot_free;
	logic [7:0] fill_len;
	logic fill_last_of_cmd;
	logic fill_active;
	logic burst_filled;
	logic beat_last;
	logic beat_fire;
	logic mismatch;
	logic wfifo_ready;
	w_beat_t wbeat_in;
	logic resp_err;

	sync_fifo #(
		.T(dma_cmd_t),
		.DEPTH(`DMA_CMD_FIFO_DEPTH)
	) cmd_fifo_inst (
		.m_axi_aclk(m_axi_aclk),
		.m_axi_aresetn(m_axi_aresetn),
		.wr_data_i(s_cmd_data_i),
		.wr_valid_i(s_cmd_valid_i),
		.wr_ready_o(s_cmd_ready_o),
		.rd_data_o(cmd),
		.rd_valid_o(cmd_valid),
		.rd_ready_i(cmd_ready)
	);

	s2mm_burst_planner planner_inst (
		.m_axi_aclk(m_axi_aclk),
		.m_axi_aresetn(m_axi_aresetn),
		.cmd_i(cmd),
		.cmd_valid_i(cmd_valid),
		.cmd_ready_o(cmd_ready),
		.slot_free_i(slot_free),
		.desc_o(desc),
		.launch_o(launch)
	);

	s2mm_burst_table table_inst (
		.m_axi_aclk(m_axi_aclk),
		.m_axi_aresetn(m_axi_aresetn),
		.desc_i(desc),
		.launch_i(launch),
		.slot_free_o(slot_free),
		.fill_len_o(fill_len),
		.fill_last_of_cmd_o(fill_last_of_cmd),
		.fill_active_o(fill_active),
		.burst_filled_i(burst_filled),
		.aw_o(m_axi_aw_o),
		.awvalid_o(m_axi_awvalid_o),
		.awready_i(m_axi_awready_i),
		.bvalid_i(m_axi_bvalid_i)
	);

	// beats only enter while a planned burst is waiting for data
	assign s_axis_ready_o = wfifo_ready & fill_active;
	assign beat_fire = s_axis_valid_i & s_axis_ready_o;

	s2mm_beat_counter counter_inst (
		.m_axi_aclk(m_axi_aclk),
		.m_axi_aresetn(m_axi_aresetn),
		.beat_fire_i(beat_fire),
		.in_last_i(s_axis_last_i),
		.fill_len_i(fill_len),
		.fill_last_of_cmd_i(fill_last_of_cmd),
		.beat_last_o(beat_last),
		.burst_filled_o(burst_filled),
		.mismatch_o(mismatch)
	);

	assign wbeat_in.data = s_axis_data_i;
	assign wbeat_in.strb = s_axis_keep_i;
	assign wbeat_in.last = beat_last; // burst boundary, not stream tlast

	sync_fifo #(
		.T(w_beat_t),
		.DEPTH(`DMA_WDATA_FIFO_DEPTH)
	) wdata_fifo_inst (
		.m_axi_aclk(m_axi_aclk),
		.m_axi_aresetn(m_axi_aresetn),
		.wr_data_i(wbeat_in),
		.wr_valid_i(s_axis_valid_i & fill_active),
		.wr_ready_o(wfifo_ready),
		.rd_data_o(m_axi_w_o),
		.rd_valid_o(m_axi_wvalid_o),
		.rd_ready_i(m_axi_wready_i)
	);

	// SLVERR and DECERR both have bresp[1] set
	always_ff @(posedge m_axi_aclk or negedge m_axi_aresetn)
	begin
		if (!m_axi_aresetn)
			resp_err <= 1'b0;
		else if (m_axi_bvalid_i && m_axi_bresp_i[1])
			resp_err <= 1'b1;
	end

	assign err_flag_o = {resp_err, mismatch};

endmodule

//--- sim/dma_s2mm_checker.sv
`include "dma_s2mm_config.svh"

module dma_s2mm_checker (
	input logic m_axi_aclk,
	input logic m_axi_aresetn,
	input axi_wr_pkg::aw_req_t aw_i,
	input logic awvalid_i,
	input logic awready_i
);

	import dma_cmd_pkg::*;
	import axi_wr_pkg::*;

	localparam int AW_CAP = `DMA_MAX_BURST_LEN;

	int fail_cnt = 0; // summed into the testbench error count

	// payload held while the slave stalls
	aw_stable_a: assert property (@(posedge m_axi_aclk) disable iff (!m_axi_aresetn)
		awvalid_i && !awready_i |=> awvalid_i && $stable(aw_i))
	else
	begin
		fail_cnt++;
		$error("AW request changed or dropped before awready");
	end

	aw_page_a: assert property (@(posedge m_axi_aclk) disable iff (!m_axi_aresetn)
		awvalid_i && aw_i.burst == AXI_BURST_INCR |->
		13'(aw_i.addr[11:0]) + ((13'(aw_i.len) + 13'd1) << BEAT_SHIFT) <= 13'd4096)
	else
	begin
		fail_cnt++;
		$error("incrementing burst crosses a 4 KB boundary");
	end

	aw_cap_a: assert property (@(posedge m_axi_aclk) disable iff (!m_axi_aresetn)
		awvalid_i |-> int'(aw_i.len) < AW_CAP)
	else
	begin
		fail_cnt++;
		$error("awlen above the burst cap");
	end

endmodule

bind dma_s2mm_top dma_s2mm_checker dma_s2mm_checker_inst (
	.m_axi_aclk(m_axi_aclk),
	.m_axi_aresetn(m_axi_aresetn),
	.aw_i(m_axi_aw_o),
	.awvalid_i(m_axi_awvalid_o),
	.awready_i(m_axi_awready_i)
);

//--- sim/tb_dma_s2mm.sv
`include "dma_s2mm_config.svh"

module tb_dma_s2mm;

	import dma_cmd_pkg::*;
	import axi_wr_pkg::*;

	localparam int MAX_LEN = `DMA_MAX_BURST_LEN;
	localparam int FIXED_LEN = (MAX_LEN > 16) ? 16 : MAX_LEN;
	localparam int NUM_CMDS = 30;
	localparam int DRAIN_LIMIT = 50000; // cycles per phase

	logic m_axi_aclk;
	logic m_axi_aresetn;
	dma_cmd_t s_cmd_data;
	logic s_cmd_valid;
	logic s_cmd_ready;
	logic [`DMA_DATA_WIDTH-1:0] s_axis_data;
	logic [`DMA_DATA_WIDTH/8-1:0] s_axis_keep;
	logic s_axis_last;
	logic s_axis_valid;
	logic s_axis_ready;
	aw_req_t m_axi_aw;
	logic m_axi_awvalid;
	logic m_axi_awready;
	w_beat_t m_axi_w;
	logic m_axi_wvalid;
	logic m_axi_wready;
	logic [1:0] m_axi_bresp;
	logic m_axi_bvalid;
	logic [1:0] err_flag;

	logic [15:0] lfsr = 16'd26991;
	int errors = 0;
	bit timed_out = 1'b0;

	dma_cmd_t cmd_q [$]; // commands not yet accepted
	w_beat_t in_q [$]; // stream beats, last holds tlast
	aw_req_t exp_aw_q [$];
	w_beat_t exp_w_q [$];
	int b_q [$]; // response delays in cycles
	int wlast_cnt = 0;
	int b_sent = 0;
	int slverr_at = -1; // index of the one SLVERR response

	dma_s2mm_top dma_s2mm_top_inst (
		.m_axi_aclk(m_axi_aclk),
		.m_axi_aresetn(m_axi_aresetn),
		.s_cmd_data_i(s_cmd_data),
		.s_cmd_valid_i(s_cmd_valid),
		.s_cmd_ready_o(s_cmd_ready),
		.s_axis_data_i(s_axis_data),
		.s_axis_keep_i(s_axis_keep),
		.s_axis_last_i(s_axis_last),
		.s_axis_valid_i(s_axis_valid),
		.s_axis_ready_o(s_axis_ready),
		.m_axi_aw_o(m_axi_aw),
		.m_axi_awvalid_o(m_axi_awvalid),
		.m_axi_awready_i(m_axi_awready),
		.m_axi_w_o(m_axi_w),
		.m_axi_wvalid_o(m_axi_wvalid),
		.m_axi_wready_i(m_axi_wready),
		.m_axi_bresp_i(m_axi_bresp),
		.m_axi_bvalid_i(m_axi_bvalid),
		.err_flag_o(err_flag)
	);

	always #20 m_axi_aclk = ~m_axi_aclk;

	// x^16 + x^14 + x^13 + x^11 + 1, one step per bit
	function automatic logic [31:0] rnd(input int n);
		logic [31:0] r;
		logic fb;
		r = '0;
		for (int i = 0; i < n; i++)
		begin
			fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
			lfsr = {lfsr[14:0], fb};
			r = {r[30:0], fb};
		end
		return r;
	endfunction

	task automatic check_val(input string name, input logic [63:0] got,
		input logic [63:0] exp);
		if (got !== exp)
		begin
			errors++;
			$display("FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp);
		end
	endtask

	// reference model, cuts a command into bursts and beats
	task automatic queue_command(input logic [23:0] btt, input logic [31:0] addr,
		input logic fixed, input bit early_last);
		dma_cmd_t c;
		aw_req_t aw;
		w_beat_t b;
		logic [31:0] a;
		int left;
		int len;
		int room;
		c.btt = btt;
		c.addr = addr;
		c.fixed = fixed;
		cmd_q.push_back(c);
		left = (int'(btt) + int'(addr[BEAT_SHIFT-1:0]) + BYTES_PER_BEAT - 1) / BYTES_PER_BEAT;
		a = {addr[31:BEAT_SHIFT], {BEAT_SHIFT{1'b0}}};
		while (left > 0)
		begin
			len = fixed ? FIXED_LEN : MAX_LEN;
			if (left < len)
				len = left;
			room = (4096 - int'(a[11:0])) / BYTES_PER_BEAT; // beats to the page end
			if (!fixed && room < len)
				len = room;
			aw.addr = a;
			aw.len = 8'(len - 1);
			aw.burst = fixed ? AXI_BURST_FIXED : AXI_BURST_INCR;
			exp_aw_q.push_back(aw);
			for (int i = 0; i < len; i++)
			begin
				b.data = rnd(`DMA_DATA_WIDTH);
				b.strb = 4'(rnd(4));
				b.last = (left == 1) || (early_last && left == 2); // early tlast too
				in_q.push_back(b);
				b.last = i == len - 1;
				exp_w_q.push_back(b);
				left--;
			end
			if (!fixed)
				a = a + 32'(len * BYTES_PER_BEAT);
		end
	endtask

	task automatic queue_random_command();
		logic [31:0] page;
		logic [31:0] addr;
		logic [23:0] btt;
		page = rnd(20);
		btt = 24'(1 + int'(rnd(9)) % 300);
		addr = (page << 12) - rnd(9); // up to 511 bytes below a boundary
		queue_command(btt, addr, rnd(1) != 0, 1'b0);
	endtask

	// one clock of stimulus and monitoring, called right after the rising edge
	task automatic bus_cycle();
		w_beat_t nb;
		aw_req_t aw_exp;
		w_beat_t w_exp;
		bit stall;
		if (s_cmd_valid && s_cmd_ready)
			void'(cmd_q.pop_front());
		s_cmd_valid <= cmd_q.size() != 0;
		if (cmd_q.size() != 0)
			s_cmd_data <= cmd_q[0];

		stall = s_axis_valid && !s_axis_ready; // must hold the beat
		if (s_axis_valid && s_axis_ready)
			void'(in_q.pop_front());
		if (!stall)
		begin
			if (in_q.size() != 0 && rnd(2) != 0)
			begin
				nb = in_q[0];
				s_axis_valid <= 1'b1;
				s_axis_data <= nb.data;
				s_axis_keep <= nb.strb;
				s_axis_last <= nb.last;
			end
			else
				s_axis_valid <= 1'b0;
		end

		if (m_axi_awvalid && m_axi_awready)
		begin
			if (exp_aw_q.size() == 0)
			begin
				errors++;
				$display("unexpected AW request at address %h", m_axi_aw.addr);
			end
			else
			begin
				aw_exp = exp_aw_q.pop_front();
				check_val("m_axi_aw_o.addr", 64'(m_axi_aw.addr), 64'(aw_exp.addr));
				check_val("m_axi_aw_o.len", 64'(m_axi_aw.len), 64'(aw_exp.len));
				check_val("m_axi_aw_o.burst", 64'(m_axi_aw.burst), 64'(aw_exp.burst));
			end
			b_q.push_back(int'(rnd(3)));
		end
		m_axi_awready <= rnd(2) != 0;

		if (m_axi_wvalid && m_axi_wready)
		begin
			if (exp_w_q.size() == 0)
			begin
				errors++;
				$display("unexpected W beat with data %h", m_axi_w.data);
			end
			else
			begin
				w_exp = exp_w_q.pop_front();
				check_val("m_axi_w_o.data", 64'(m_axi_w.data), 64'(w_exp.data));
				check_val("m_axi_w_o.strb", 64'(m_axi_w.strb), 64'(w_exp.strb));
				check_val("m_axi_w_o.last", 64'(m_axi_w.last), 64'(w_exp.last));
			end
			if (m_axi_w.last)
				wlast_cnt++;
		end
		m_axi_wready <= rnd(2) != 0;

		// a response only after its burst's wlast
		m_axi_bvalid <= 1'b0;
		if (b_q.size() != 0 && wlast_cnt > b_sent)
		begin
			if (b_q[0] == 0)
			begin
				void'(b_q.pop_front());
				m_axi_bvalid <= 1'b1;
				m_axi_bresp <= (b_sent == slverr_at) ? 2'b10 : 2'b00;
				b_sent++;
			end
			else
				b_q[0] = b_q[0] - 1;
		end
	endtask

	function automatic int pending();
		return cmd_q.size() + in_q.size() + exp_aw_q.size() + exp_w_q.size() + b_q.size();
	endfunction

	task automatic run_until_drained(input string phase);
		int n;
		n = 0;
		while (!timed_out && pending() != 0)
		begin
			@(posedge m_axi_aclk);
			bus_cycle();
			n++;
			if (n == DRAIN_LIMIT)
			begin
				timed_out = 1'b1;
				errors++;
				$display("timeout: %s did not drain within %0d cycles", phase, DRAIN_LIMIT);
			end
		end
		repeat (2) // last response reaches the error flag
		begin
			@(posedge m_axi_aclk);
			bus_cycle();
		end
	endtask

	initial
	begin
		m_axi_aclk = 1'b0;
		m_axi_aresetn = 1'b0;
		s_cmd_data = '0;
		s_cmd_valid = 1'b0;
		s_axis_data = '0;
		s_axis_keep = '0;
		s_axis_last = 1'b0;
		s_axis_valid = 1'b0;
		m_axi_awready = 1'b0;
		m_axi_wready = 1'b0;
		m_axi_bresp = 2'b00;
		m_axi_bvalid = 1'b0;
		repeat (5) @(posedge m_axi_aclk);
		m_axi_aresetn <= 1'b1;
		@(posedge m_axi_aclk);
		check_val("s_cmd_ready_o", 64'(s_cmd_ready), 64'd1);
		check_val("m_axi_awvalid_o", 64'(m_axi_awvalid), 64'd0);
		check_val("m_axi_wvalid_o", 64'(m_axi_wvalid), 64'd0);
		check_val("err_flag_o", 64'(err_flag), 64'd0);

		queue_command(24'd200, 32'h0000_8100, 1'b1, 1'b0); // fixed, 50 beats
		queue_command(24'd64, 32'h0000_1ff0, 1'b0, 1'b0); // page split after 4 beats
		for (int i = 0; i < NUM_CMDS; i++)
			queue_random_command();
		run_until_drained("random traffic");
		check_val("err_flag_o", 64'(err_flag), 64'd0); // all OKAY so far

		// early tlast and one SLVERR on the same burst
		slverr_at = b_sent;
		queue_command(24'd40, 32'h0000_3000, 1'b0, 1'b1);
		run_until_drained("error command");
		check_val("err_flag_o", 64'(err_flag), 64'd3);

		queue_command(24'd24, 32'h0000_4004, 1'b1, 1'b0);
		run_until_drained("clean command");
		check_val("err_flag_o", 64'(err_flag), 64'd3); // sticky

		if (pending() != 0)
		begin
			errors++;
			$display("entries left over: %0d commands, %0d stream beats, %0d AW, %0d W, %0d B",
				cmd_q.size(), in_q.size(), exp_aw_q.size(), exp_w_q.size(), b_q.size());
		end
		errors += dma_s2mm_top_inst.dma_s2mm_checker_inst.fail_cnt;
		$display("run complete, %0d errors", errors);
		if (errors == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

endmodule

//--- sources.f
+incdir+rtl
rtl/dma_cmd_pkg.sv
rtl/axi_wr_pkg.sv
rtl/sync_fifo.sv
rtl/s2mm_burst_planner.sv
rtl/s2mm_burst_table.sv
rtl/s2mm_beat_counter.sv
rtl/dma_s2mm_top.sv
sim/dma_s2mm_checker.sv
sim/tb_dma_s2mm.sv

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal -f sources.f --top-module tb_dma_s2mm \
	-Mdir obj_dir -o sim_dma_s2mm
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

out=$(./obj_dir/sim_dma_s2mm +verilator+error+limit+100)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$out" | grep -qx "Test passed"; then
	exit 0
fi
exit 1
